//--- run_sim.sh
#!/usr/bin/env bash
# Build the timer testbench with Verilator, run it and scan the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_mfp_timer -o sim_mfp_timer

./obj_dir/sim_mfp_timer | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

//--- sources.f
verilog/mfp_timer_pkg.sv
verilog/mfp_input_sync.sv
verilog/mfp_timer_regs.sv
verilog/mfp_tick_gen.sv
verilog/mfp_down_counter.sv
verilog/mfp_timer_top.sv
test/tb_mfp_timer.sv

//--- test/mfp_timer_tests.txt
# columns: command operand, CHECK takes dat_o t_o pulse_count ctrl_o
# -1 in a CHECK field means model only, WDATA -1 writes a random value
# test 1 reset and stopped load
CHECK 0 0 0 0
WDATA 37
CHECK 37 0 0 0
WCTRL 7
CHECK 37 0 0 7
WCTRL 0
CHECK 37 0 0 0
END
# test 2 event mode
WDATA 5
WCTRL 8
TRIG 3
CHECK 2 0 0 8
TRIG 2
CHECK 5 1 1 8
TRIG 1
CHECK 4 1 1 8
WCTRL 0
END
# test 3 delay mode over all prescaler selections
WDATA 3
WCTRL 1
XCLK 9
CHECK 1 1 1 1
XCLK 3
CHECK 3 0 2 1
WCTRL 2
XCLK 25
CHECK 1 0 2 2
WCTRL 3
XCLK 11
CHECK 3 1 3 3
WCTRL 4
XCLK 100
CHECK 1 1 3 4
WCTRL 5
XCLK 64
CHECK 3 0 4 5
WCTRL 6
XCLK 150
CHECK 2 0 4 6
WCTRL 7
XCLK 150
CHECK 1 0 4 7
WCTRL 0
END
# test 4 pulse mode, writes while running, random reload and reload 0
WDATA 4
WCTRL 9
GATE 0
XCLK 8
CHECK 4 0 4 9
GATE 1
XCLK 8
CHECK 2 0 4 9
WDATA 6
CHECK 2 0 4 9
XCLK 8
CHECK 6 1 5 9
WDATA -1
XCLK 24
CHECK -1 0 6 9
WCTRL 0
WDATA 0
WCTRL 9
XCLK 4
CHECK 255 0 6 9
XCLK 1016
CHECK 1 0 6 9
XCLK 4
CHECK 0 1 7 9
END
# test 5 force low, then stop
WCTRL 25
CHECK 0 0 7 9
WCTRL 0
GATE 0
XCLK 8
TRIG 2
CHECK 0 0 7 0
END

//--- test/tb_mfp_timer.sv
/*
  Data-driven testbench for the MFP-style timer.
  Reads commands and expected values from test/mfp_timer_tests.txt, drives the
  CPU strobes and the xclk and t_i pins on the falling edge, and compares the
  DUT with a reference model of the timer and with the values in the file.
*/
`default_nettype none

module tb_mfp_timer;

  logic       CLK;
  logic       rst;
  logic       dat_we;
  logic [7:0] dat_i;
  logic       ctrl_we;
  logic [4:0] ctrl_i;
  logic       xclk;
  logic       t_i;
  logic [7:0] dat_o;
  logic [3:0] ctrl_o;
  logic       pulse_mode;
  logic       t_o;
  logic       t_o_pulse;

  // reference model state
  logic [7:0] m_data;
  logic [3:0] m_ctrl;
  logic [7:0] m_count;
  logic       m_to;
  logic       m_gate;
  int         m_div;
  int         m_pulses;

  // t_o_pulse events seen on the DUT
  int pulse_cnt;

  int     fd;
  integer seed;
  int     cmd_no;
  int     test_no;
  int     test_errors;
  int     errors;
  int     checks;

  mfp_timer_top dut_i (
    .CLK        (CLK),
    .rst        (rst),
    .dat_we     (dat_we),
    .dat_i      (dat_i),
    .ctrl_we    (ctrl_we),
    .ctrl_i     (ctrl_i),
    .xclk       (xclk),
    .t_i        (t_i),
    .dat_o      (dat_o),
    .ctrl_o     (ctrl_o),
    .pulse_mode (pulse_mode),
    .t_o        (t_o),
    .t_o_pulse  (t_o_pulse)
  );

  always #5 CLK = ~CLK;

  // a one-cycle pulse is high across exactly one falling edge
  always @(negedge CLK) begin
    if (rst) begin
      pulse_cnt <= 0;
    end else if (t_o_pulse) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  // xclk division ratio per prescaler selection
  function automatic int prescale_ratio(input logic [2:0] sel);
    case (sel)
      3'd1:    return 4;
      3'd2:    return 10;
      3'd3:    return 16;
      3'd4:    return 50;
      3'd5:    return 64;
      3'd6:    return 100;
      3'd7:    return 200;
      default: return 1;
    endcase
  endfunction

  // 0000 stop, 0xxx delay, 1000 event, 1xxx pulse
  function automatic mfp_timer_pkg::timer_mode_e decode_mode(input logic [3:0] c);
    if (c == 4'd0) begin
      return mfp_timer_pkg::MODE_STOP;
    end else if (!c[3]) begin
      return mfp_timer_pkg::MODE_DELAY;
    end else if (c[2:0] == 3'd0) begin
      return mfp_timer_pkg::MODE_EVENT;
    end else begin
      return mfp_timer_pkg::MODE_PULSE;
    end
  endfunction

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
    end
  endtask

  // one count step of the model counter
  task automatic count_step;
    if (m_count == 8'd1) begin
      m_count  = m_data;
      m_to     = ~m_to;
      m_pulses = m_pulses + 1;
    end else begin
      m_count = m_count - 8'd1;
    end
  endtask

  // prescaler and gating for one xclk rising edge
  task automatic model_xclk_edge;
    mfp_timer_pkg::timer_mode_e mode;
    int ratio;
    mode  = decode_mode(m_ctrl);
    ratio = prescale_ratio(m_ctrl[2:0]);
    if (mode == mfp_timer_pkg::MODE_DELAY || mode == mfp_timer_pkg::MODE_PULSE) begin
      if (m_div >= ratio - 1) begin
        m_div = 0;
        if (mode == mfp_timer_pkg::MODE_DELAY || m_gate) begin
          count_step();
        end
      end else begin
        m_div = m_div + 1;
      end
    end
  endtask

  // t_i rising edge, counted in event mode only
  task automatic model_trig_rise;
    if (decode_mode(m_ctrl) == mfp_timer_pkg::MODE_EVENT) begin
      count_step();
    end
  endtask

  task automatic write_data_cmd(input logic [7:0] v);
    m_data = v;
    // direct load only while stopped
    if (decode_mode(m_ctrl) == mfp_timer_pkg::MODE_STOP) begin
      m_count = v;
    end
    dat_i  = v;
    dat_we = 1'b1;
    wait_cycles(1);
    dat_we = 1'b0;
    wait_cycles(2);
  endtask

  task automatic write_ctrl_cmd(input logic [4:0] v);
    mfp_timer_pkg::timer_mode_e mode;
    m_ctrl = v[3:0];
    if (v[4]) begin
      m_to = 1'b0;
    end
    mode = decode_mode(m_ctrl);
    // divider held clear outside the xclk modes
    if (mode == mfp_timer_pkg::MODE_STOP || mode == mfp_timer_pkg::MODE_EVENT) begin
      m_div = 0;
    end
    ctrl_i  = v;
    ctrl_we = 1'b1;
    wait_cycles(1);
    ctrl_we = 1'b0;
    wait_cycles(2);
  endtask

  // 4 cycles per level
  task automatic pulse_xclk(input int n);
    for (int i = 0; i < n; i++) begin
      xclk = 1'b1;
      model_xclk_edge();
      wait_cycles(4);
      xclk = 1'b0;
      wait_cycles(4);
    end
  endtask

  task automatic pulse_trig(input int n);
    for (int i = 0; i < n; i++) begin
      if (!m_gate) begin
        model_trig_rise();
      end
      t_i    = 1'b1;
      m_gate = 1'b1;
      wait_cycles(4);
      t_i    = 1'b0;
      m_gate = 1'b0;
      wait_cycles(4);
    end
  endtask

  task automatic set_gate(input logic v);
    if (v && !m_gate) begin
      model_trig_rise();
    end
    t_i    = v;
    m_gate = v;
    wait_cycles(8);
  endtask

  task automatic read_int(output int v);
    int r;
    r = $fscanf(fd, "%d", v);
    if (r != 1) begin
      $display("test file ends in the middle of command %0d", cmd_no);
      errors = errors + 1;
      v = 0;
    end
  endtask

  // a file value below 0 leaves the field to the model alone
  task automatic compare_field(input string name, input int got, input int model_val,
                               input int file_val);
    checks = checks + 1;
    if (got != model_val) begin
      $display("[ERROR] t=%0t command %0d: %s is %0d, model gives %0d",
               $time, cmd_no, name, got, model_val);
      errors      = errors + 1;
      test_errors = test_errors + 1;
    end
    if (file_val >= 0 && got != file_val) begin
      $display("[ERROR] t=%0t command %0d: %s is %0d, test file gives %0d",
               $time, cmd_no, name, got, file_val);
      errors      = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  task automatic check_outputs;
    int e_cnt;
    int e_to;
    int e_pulses;
    int e_ctrl;
    int is_pulse;
    read_int(e_cnt);
    read_int(e_to);
    read_int(e_pulses);
    read_int(e_ctrl);
    // pin edge to dat_o is 6 cycles
    wait_cycles(8);
    is_pulse = (decode_mode(m_ctrl) == mfp_timer_pkg::MODE_PULSE) ? 1 : 0;
    compare_field("dat_o", int'(dat_o), int'(m_count), e_cnt);
    compare_field("t_o", int'(t_o), int'(m_to), e_to);
    compare_field("pulse count", pulse_cnt, m_pulses, e_pulses);
    compare_field("ctrl_o", int'(ctrl_o), int'(m_ctrl), e_ctrl);
    compare_field("pulse_mode", int'(pulse_mode), is_pulse, -1);
  endtask

  task automatic run_tests;
    string            op;
    int               r;
    int               arg;
    logic [8*160-1:0] skip_line;
    bit               done;
    done = 1'b0;
    while (!done) begin
      r = $fscanf(fd, "%s", op);
      if (r != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        r = $fgets(skip_line, fd);
      end else begin
        cmd_no = cmd_no + 1;
        if (cmd_no > 400) begin
          $display("test file did not end within 400 commands");
          errors = errors + 1;
          done   = 1'b1;
        end else if (op == "WDATA") begin
          read_int(arg);
          if (arg < 0) begin
            arg = $random(seed) & 255;
            $display("random reload value %0d", arg);
          end
          write_data_cmd(arg[7:0]);
        end else if (op == "WCTRL") begin
          read_int(arg);
          write_ctrl_cmd(arg[4:0]);
        end else if (op == "XCLK") begin
          read_int(arg);
          pulse_xclk(arg);
        end else if (op == "TRIG") begin
          read_int(arg);
          pulse_trig(arg);
        end else if (op == "GATE") begin
          read_int(arg);
          set_gate(arg != 0);
        end else if (op == "CHECK") begin
          check_outputs();
        end else if (op == "END") begin
          $display("test %0d finished with %0d errors", test_no, test_errors);
          test_no     = test_no + 1;
          test_errors = 0;
        end else begin
          $display("unknown command %s in the test file", op);
          errors = errors + 1;
          done   = 1'b1;
        end
      end
    end
  endtask

  initial begin
    int wait_n;
    CLK         = 1'b0;
    rst         = 1'b1;
    dat_we      = 1'b0;
    dat_i       = 8'd0;
    ctrl_we     = 1'b0;
    ctrl_i      = 5'd0;
    xclk        = 1'b0;
    t_i         = 1'b0;
    m_data      = 8'd0;
    m_ctrl      = 4'd0;
    m_count     = 8'd0;
    m_to        = 1'b0;
    m_gate      = 1'b0;
    m_div       = 0;
    m_pulses    = 0;
    seed        = 64;
    cmd_no      = 0;
    test_no     = 1;
    test_errors = 0;
    errors      = 0;
    checks      = 0;
    wait_cycles(4);
    rst = 1'b0;
    // outputs should already be clear after reset
    wait_n = 0;
    while (wait_n < 10 && (dat_o !== 8'd0 || t_o !== 1'b0 || t_o_pulse !== 1'b0)) begin
      wait_cycles(1);
      wait_n = wait_n + 1;
    end
    if (wait_n == 10) begin
      $display("DUT outputs did not clear within 10 cycles after reset");
      errors = errors + 1;
    end
    fd = $fopen("test/mfp_timer_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file test/mfp_timer_tests.txt");
      $display("*** TEST FAILED ***");
    end else begin
      run_tests();
      $fclose(fd);
      $display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
      if (errors == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/mfp_down_counter.sv
/*
  Third pipeline stage of the timer.
  8-bit down-counter that reloads from the data register when it reaches 1,
  toggling t_o and raising a one-cycle t_o_pulse on each reload.
  The counter value is registered once more for the CPU read-back on dat_o.
*/
`default_nettype none

module mfp_down_counter (
  input  wire                              CLK,
  input  wire                              rst,
  input  wire                              count_en,
  input  wire mfp_timer_pkg::timer_ctrl_t  ctrl,
  input  wire mfp_timer_pkg::reg_cmd_t     cmd,
  output logic [7:0]                       dat_o,
  output logic                             t_o,
  output logic                             t_o_pulse
);

  logic [mfp_timer_pkg::COUNT_W-1:0] count_q;

  logic stopped;
  // a count step arrives while the timer runs
  logic step;
  // the step hits the terminal count
  logic timeout;

  always_comb begin
    stopped = (ctrl.mode == mfp_timer_pkg::MODE_STOP);
    // an enable still in flight when the timer stops is dropped
    step    = count_en & ~stopped;
    timeout = step & (count_q == 8'd1);
  end

  // counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      count_q <= '0;
    end else if (cmd.data_wr && stopped) begin
      // direct load only while stopped, else next reload picks it up
      count_q <= cmd.data;
    end else if (timeout) begin
      count_q <= cmd.data;
    end else if (step) begin
      // 0 wraps to 255, so a reload of 0 gives 256 ticks
      count_q <= count_q - 8'd1;
    end
  end

  // timer output and timeout pulse
  always_ff @(posedge CLK) begin
    if (rst) begin
      t_o       <= 1'b0;
      t_o_pulse <= 1'b0;
    end else begin
      t_o_pulse <= timeout;
      if (cmd.t_o_clear) begin
        // force low wins over a toggle in the same cycle
        t_o <= 1'b0;
      end else if (timeout) begin
        t_o <= ~t_o;
      end
    end
  end

  // read-back copy, one cycle behind the counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= count_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mfp_input_sync.sv
/*
  First pipeline stage of the timer.
  Brings the asynchronous t_i and xclk pins into the CLK domain with
  two-flop synchronizers and registers their rising edges and the t_i level.
  A pin edge shows up on ev three cycles later.
*/
`default_nettype none

module mfp_input_sync (
  input  wire                          CLK,
  input  wire                          rst,
  input  wire logic                    t_i,
  input  wire logic                    xclk,
  output mfp_timer_pkg::sync_events_t  ev
);

  // synchronizer chains, index 0 is the metastable flop
  logic [1:0] trig_sync;
  logic [1:0] xclk_sync;

  // previous synchronized levels for edge detection
  logic trig_prev;
  logic xclk_prev;

  always_ff @(posedge CLK) begin
    if (rst) begin
      trig_sync <= 2'b00;
      xclk_sync <= 2'b00;
      trig_prev <= 1'b0;
      xclk_prev <= 1'b0;
      ev        <= '0;
    end else begin
      trig_sync <= {trig_sync[0], t_i};
      xclk_sync <= {xclk_sync[0], xclk};
      trig_prev <= trig_sync[1];
      xclk_prev <= xclk_sync[1];
      // edge flop, high for one cycle per rising edge
      ev.trig_rise  <= trig_sync[1] & ~trig_prev;
      ev.xclk_rise  <= xclk_sync[1] & ~xclk_prev;
      // level is delayed the same amount as the edges
      ev.trig_level <= trig_sync[1];
    end
  end

endmodule

`default_nettype wire

//--- verilog/mfp_tick_gen.sv
/*
  Second pipeline stage of the timer.
  Divides synchronized xclk edges by the selected prescaler and gates the
  result by mode, producing a registered one-cycle count enable.
  Event mode passes t_i rising edges straight through instead.
*/
`default_nettype none

module mfp_tick_gen (
  input  wire                               CLK,
  input  wire                               rst,
  input  wire mfp_timer_pkg::sync_events_t  ev,
  input  wire mfp_timer_pkg::timer_ctrl_t   ctrl,
  output logic                              count_en
);

  logic [mfp_timer_pkg::PRESC_W-1:0] div_q;
  logic [mfp_timer_pkg::PRESC_W-1:0] limit;

  // divider runs in the two xclk based modes only
  logic use_div;
  // divider sits on its terminal value at an xclk edge
  logic div_wrap;
  logic tick;
  logic count_next;

  always_comb begin
    limit    = mfp_timer_pkg::presc_limit(ctrl.presc_sel);
    use_div  = (ctrl.mode == mfp_timer_pkg::MODE_DELAY) ||
               (ctrl.mode == mfp_timer_pkg::MODE_PULSE);
    // >= also catches a divider left above a smaller new limit
    div_wrap = (div_q >= limit);
    tick     = use_div & ev.xclk_rise & div_wrap;
  end

  // mode gating of the prescaled tick
  always_comb begin
    case (ctrl.mode)
      mfp_timer_pkg::MODE_DELAY: count_next = tick;
      mfp_timer_pkg::MODE_PULSE: count_next = tick & ev.trig_level;
      mfp_timer_pkg::MODE_EVENT: count_next = ev.trig_rise;
      default:                   count_next = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_q    <= '0;
      count_en <= 1'b0;
    end else begin
      count_en <= count_next;
      if (!use_div) begin
        // stopped or event mode, hold the divider at zero
        div_q <= '0;
      end else if (ev.xclk_rise) begin
        if (div_wrap) begin
          div_q <= '0;
        end else begin
          div_q <= div_q + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mfp_timer_pkg.sv
/*
  Shared types and constants for the MFP-style timer.
  Holds the mode enum, the control, event and register command structs,
  the counter widths and the prescaler terminal table.
  Every timer module refers to these by scoped name.
*/
`default_nettype none

package mfp_timer_pkg;

  // counter / reload register width
  localparam int COUNT_W = 8;
  // prescaler divider counter width, big enough for a terminal value of 199
  localparam int PRESC_W = 8;

  // operating mode decoded from control bits [3:0]
  typedef enum logic [1:0] {
    MODE_STOP  = 2'd0,
    MODE_DELAY = 2'd1,
    MODE_EVENT = 2'd2,
    MODE_PULSE = 2'd3
  } timer_mode_e;

  // decoded control word, 5 bits
  typedef struct packed {
    timer_mode_e mode;
    logic [2:0]  presc_sel;
  } timer_ctrl_t;

  // synchronized pin events, all in the CLK domain
  typedef struct packed {
    logic trig_rise;   // one cycle on a t_i rising edge
    logic trig_level;  // t_i level after the synchronizer
    logic xclk_rise;   // one cycle on an xclk rising edge
  } sync_events_t;

  // register side commands to the counter, 10 bits
  typedef struct packed {
    logic               data_wr;    // a data write happened last cycle
    logic [COUNT_W-1:0] data;       // reload value, already updated
    logic               t_o_clear;  // control write with bit 4 set
  } reg_cmd_t;

  // divider terminal value per prescaler selection
  // the divider counts 0..limit, so the ratio is limit + 1
  function automatic logic [PRESC_W-1:0] presc_limit(input logic [2:0] sel);
    case (sel)
      3'd1:    return 8'd3;    // /4
      3'd2:    return 8'd9;    // /10
      3'd3:    return 8'd15;   // /16
      3'd4:    return 8'd49;   // /50
      3'd5:    return 8'd63;   // /64
      3'd6:    return 8'd99;   // /100
      3'd7:    return 8'd199;  // /200
      // only seen while stopped or in event mode
      default: return 8'd1;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/mfp_timer_regs.sv
/*
  CPU register block of the timer.
  Holds the 8-bit data (reload) register and the 4-bit control register,
  decodes the timer mode and hands write and clear pulses to the counter.
  Writes are single-cycle strobes and take effect on the next edge.
*/
`default_nettype none

module mfp_timer_regs (
  input  wire                         CLK,
  input  wire                         rst,
  input  wire                         dat_we,
  input  wire  [7:0]                  dat_i,
  input  wire                         ctrl_we,
  input  wire  [4:0]                  ctrl_i,
  output logic [3:0]                  ctrl_o,
  output logic                        pulse_mode,
  output mfp_timer_pkg::timer_ctrl_t  ctrl,
  output mfp_timer_pkg::reg_cmd_t     cmd
);

  logic [mfp_timer_pkg::COUNT_W-1:0] data_q;
  logic [3:0]                        ctrl_q;

  // command pulses, aligned with the register update
  logic data_wr_q;
  logic t_o_clear_q;

  always_ff @(posedge CLK) begin
    if (rst) begin
      data_q      <= '0;
      ctrl_q      <= 4'd0;
      data_wr_q   <= 1'b0;
      t_o_clear_q <= 1'b0;
    end else begin
      data_wr_q   <= dat_we;
      // bit 4 of a control write forces t_o low, it is not stored
      t_o_clear_q <= ctrl_we & ctrl_i[4];
      if (dat_we) begin
        data_q <= dat_i;
      end
      if (ctrl_we) begin
        ctrl_q <= ctrl_i[3:0];
      end
    end
  end

  // mode decode
  // 0000 stop, 0xxx delay, 1000 event, 1xxx pulse
  always_comb begin
    if (ctrl_q == 4'd0) begin
      ctrl.mode = mfp_timer_pkg::MODE_STOP;
    end else if (!ctrl_q[3]) begin
      ctrl.mode = mfp_timer_pkg::MODE_DELAY;
    end else if (ctrl_q[2:0] == 3'd0) begin
      ctrl.mode = mfp_timer_pkg::MODE_EVENT;
    end else begin
      ctrl.mode = mfp_timer_pkg::MODE_PULSE;
    end
    ctrl.presc_sel = ctrl_q[2:0];
  end

  // command to the counter, data already holds the written value
  always_comb begin
    cmd.data_wr   = data_wr_q;
    cmd.data      = data_q;
    cmd.t_o_clear = t_o_clear_q;
  end

  // cpu read-back of the stored control bits
  assign ctrl_o = ctrl_q;

  // pulse mode masks the input port interrupt in a full MFP
  assign pulse_mode = (ctrl.mode == mfp_timer_pkg::MODE_PULSE);

endmodule

`default_nettype wire

//--- verilog/mfp_timer_top.sv
/*
  Top level of the MFP-style timer.
  Connects the CPU register block to the three pipeline stages:
  input synchronizer, tick generator and down-counter.
*/
`default_nettype none

module mfp_timer_top (
  input  wire        CLK,
  input  wire        rst,
  input  wire        dat_we,
  input  wire  [7:0] dat_i,
  input  wire        ctrl_we,
  input  wire  [4:0] ctrl_i,
  input  wire        xclk,
  input  wire        t_i,
  output logic [7:0] dat_o,
  output logic [3:0] ctrl_o,
  output logic       pulse_mode,
  output logic       t_o,
  output logic       t_o_pulse
);

  mfp_timer_pkg::timer_ctrl_t  ctrl;
  mfp_timer_pkg::reg_cmd_t     cmd;
  mfp_timer_pkg::sync_events_t ev;
  logic                        count_en;

  // cpu registers and mode decode
  mfp_timer_regs regs_i (
    .CLK        (CLK),
    .rst        (rst),
    .dat_we     (dat_we),
    .dat_i      (dat_i),
    .ctrl_we    (ctrl_we),
    .ctrl_i     (ctrl_i),
    .ctrl_o     (ctrl_o),
    .pulse_mode (pulse_mode),
    .ctrl       (ctrl),
    .cmd        (cmd)
  );

  // stage 1, pins into the CLK domain
  mfp_input_sync sync_i (
    .CLK  (CLK),
    .rst  (rst),
    .t_i  (t_i),
    .xclk (xclk),
    .ev   (ev)
  );

  // stage 2, prescaler and mode gating
  mfp_tick_gen tick_i (
    .CLK      (CLK),
    .rst      (rst),
    .ev       (ev),
    .ctrl     (ctrl),
    .count_en (count_en)
  );

  // stage 3, down-counter and timer output
  mfp_down_counter cnt_i (
    .CLK       (CLK),
    .rst       (rst),
    .count_en  (count_en),
    .ctrl      (ctrl),
    .cmd       (cmd),
    .dat_o     (dat_o),
    .t_o       (t_o),
    .t_o_pulse (t_o_pulse)
  );

endmodule

`default_nettype wire
